// ==== hw/core_pkg.sv ====
package core_pkg;

    // register and memory word width.
    localparam int DATA_W = 32;

    // four architectural registers.
    localparam int REG_W = 2;

    // instruction word: op [15:13], rd [12:11], rs [10:9], signed imm [8:0].
    typedef enum logic [2:0] {
        op_nop   = 3'd0,
        op_add   = 3'd1,
        op_sub   = 3'd2,
        op_and   = 3'd3,
        op_xor   = 3'd4,
        op_addi  = 3'd5,
        op_load  = 3'd6,
        op_store = 3'd7
    } op_e;

    // decode to register read.
    typedef struct packed {
        logic              valid;
        op_e               op;
        logic [REG_W-1:0]  rd;
        logic [REG_W-1:0]  rs;
        logic [DATA_W-1:0] imm;
    } dec_uop_t;

    // register read to memory/execute.
    // rd_value is the store data or first alu operand.
    typedef struct packed {
        logic              valid;
        op_e               op;
        logic [REG_W-1:0]  rd;
        logic [DATA_W-1:0] rd_value;
        logic [DATA_W-1:0] rs_value;
        logic [DATA_W-1:0] addr;
    } mem_uop_t;

    typedef struct packed {
        logic [REG_W-1:0]  rd;
        logic [DATA_W-1:0] value;
        logic              is_store;
        logic [DATA_W-1:0] addr;
    } retire_t;

endpackage

// ==== hw/pipe_latch.sv ====
module pipe_latch #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     ld,
    input  logic     clr,
    input  payload_t d,
    output payload_t q
);

    // clear wins over load, so a stall turns the stage into a bubble.
    always_ff @(posedge clk) begin
        if (clr) begin
            q <= '0;
        end else if (ld) begin
            q <= d;
        end
    end

endmodule

// ==== hw/uop_decode.sv ====
module uop_decode (
    input  logic                instr_valid,
    input  logic [15:0]         instr,
    output core_pkg::dec_uop_t  uop
);

    import core_pkg::*;

    op_e              op;
    logic [8:0]       imm_field;
    logic [REG_W-1:0] rd_field;
    logic [REG_W-1:0] rs_field;

    assign op        = op_e'(instr[15:13]);
    assign rd_field  = instr[12:11];
    assign rs_field  = instr[10:9];
    assign imm_field = instr[8:0];

    always_comb begin
        // nops are dropped here so they never reach later stages.
        uop.valid = instr_valid && (op != op_nop);
        uop.op    = op;
        uop.rd    = rd_field;
        uop.rs    = rs_field;
        uop.imm   = {{(DATA_W - 9){imm_field[8]}}, imm_field};
    end

endmodule

// ==== hw/rrag_stage.sv ====
module rrag_stage #(
    parameter int MEM_WORDS = 16,
    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1
) (
    input  logic                          clk,
    input  logic                          reset,
    input  core_pkg::dec_uop_t            uop,
    input  logic                          wb_valid,
    input  logic [core_pkg::REG_W-1:0]    wb_rd,
    input  logic [core_pkg::DATA_W-1:0]   wb_value,
    input  logic                          pending_store_valid,
    input  logic [IDX_W-1:0]              pending_store_index,
    output logic                          stall,
    output logic [IDX_W-1:0]              mem_rd_index,
    output core_pkg::mem_uop_t            mem_uop
);

    import core_pkg::*;

    logic [DATA_W-1:0] regs [1 << REG_W];
    logic [DATA_W-1:0] rd_value;
    logic [DATA_W-1:0] rs_value;
    logic [DATA_W-1:0] addr;

    // a write in the same cycle is forwarded to the reader.
    function automatic logic [DATA_W-1:0] read_reg(input logic [REG_W-1:0] idx);
        if (wb_valid && (wb_rd == idx)) begin
            return wb_value;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < (1 << REG_W); i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb_rd] <= wb_value;
        end
    end

    always_comb begin
        rd_value = read_reg(uop.rd);
        rs_value = read_reg(uop.rs);
    end

    assign addr = rs_value + uop.imm;

    // word index wraps modulo the memory depth.
    assign mem_rd_index = IDX_W'(addr % DATA_W'(MEM_WORDS));

    always_comb begin
        mem_uop.valid    = uop.valid;
        mem_uop.op       = uop.op;
        mem_uop.rd       = uop.rd;
        mem_uop.rd_value = rd_value;
        mem_uop.rs_value = (uop.op == op_addi) ? uop.imm : rs_value;
        mem_uop.addr     = addr;
    end

    // the store ahead is written on the same edge the load would sample
    // memory, so the load waits one cycle.
    assign stall = uop.valid && (uop.op == op_load) &&
                   pending_store_valid && (pending_store_index == mem_rd_index);

endmodule

// ==== hw/mem_execute.sv ====
module mem_execute #(
    parameter int MEM_WORDS = 16,
    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1
) (
    input  logic                          clk,
    input  logic                          reset,
    input  core_pkg::mem_uop_t            uop,
    input  logic [IDX_W-1:0]              mem_rd_index,
    output logic                          pending_store_valid,
    output logic [IDX_W-1:0]              pending_store_index,
    output logic                          wb_valid,
    output logic [core_pkg::REG_W-1:0]    wb_rd,
    output logic [core_pkg::DATA_W-1:0]   wb_value,
    output logic                          retire_valid,
    output core_pkg::retire_t             retire
);

    import core_pkg::*;

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [DATA_W-1:0] rd_data;
    logic [DATA_W-1:0] result;
    logic              is_store;
    logic              is_mem_op;

    assign is_store  = uop.valid && (uop.op == op_store);
    assign is_mem_op = (uop.op == op_load) || (uop.op == op_store);

    assign pending_store_valid = is_store;
    assign pending_store_index = IDX_W'(uop.addr % DATA_W'(MEM_WORDS));

    // read is sampled on the edge where the load enters this stage.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (is_store) begin
            mem[pending_store_index] <= uop.rd_value;
        end
        rd_data <= mem[mem_rd_index];
    end

    always_comb begin
        case (uop.op)
            op_add:  result = uop.rd_value + uop.rs_value;
            op_sub:  result = uop.rd_value - uop.rs_value;
            op_and:  result = uop.rd_value & uop.rs_value;
            op_xor:  result = uop.rd_value ^ uop.rs_value;
            op_addi: result = uop.rd_value + uop.rs_value;
            op_load: result = rd_data;
            default: result = '0;
        endcase
    end

    assign wb_valid = uop.valid && (uop.op != op_store);
    assign wb_rd    = uop.rd;
    assign wb_value = result;

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= uop.valid;
        end
    end

    // addr is only meaningful for loads and stores; alu ops report zero.
    always_ff @(posedge clk) begin
        retire.rd       <= uop.rd;
        retire.value    <= (uop.op == op_store) ? uop.rd_value : result;
        retire.is_store <= (uop.op == op_store);
        retire.addr     <= is_mem_op ? uop.addr : '0;
    end

endmodule

// ==== hw/pipe_core.sv ====
module pipe_core #(
    parameter int MEM_WORDS = 16,
    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               instr_valid,
    input  logic [15:0]        instr,
    output logic               stall,
    output logic               retire_valid,
    output core_pkg::retire_t  retire
);

    import core_pkg::*;

    dec_uop_t          dec_uop;
    dec_uop_t          rrag_uop;
    mem_uop_t          rrag_mem_uop;
    mem_uop_t          mem_uop;
    logic [IDX_W-1:0]  mem_rd_index;
    logic              pending_store_valid;
    logic [IDX_W-1:0]  pending_store_index;
    logic              wb_valid;
    logic [REG_W-1:0]  wb_rd;
    logic [DATA_W-1:0] wb_value;

    uop_decode uop_decode_inst (
        .instr_valid (instr_valid),
        .instr       (instr),
        .uop         (dec_uop)
    );

    // holds during a stall so the load is retried.
    pipe_latch #(.payload_t(dec_uop_t)) dec_rrag_latch (
        .clk (clk),
        .ld  (!stall),
        .clr (reset),
        .d   (dec_uop),
        .q   (rrag_uop)
    );

    rrag_stage #(.MEM_WORDS(MEM_WORDS)) rrag_stage_inst (
        .clk                 (clk),
        .reset               (reset),
        .uop                 (rrag_uop),
        .wb_valid            (wb_valid),
        .wb_rd               (wb_rd),
        .wb_value            (wb_value),
        .pending_store_valid (pending_store_valid),
        .pending_store_index (pending_store_index),
        .stall               (stall),
        .mem_rd_index        (mem_rd_index),
        .mem_uop             (rrag_mem_uop)
    );

    // a stall sends a bubble into the memory stage.
    pipe_latch #(.payload_t(mem_uop_t)) rrag_mem_latch (
        .clk (clk),
        .ld  (1'b1),
        .clr (reset || stall),
        .d   (rrag_mem_uop),
        .q   (mem_uop)
    );

    mem_execute #(.MEM_WORDS(MEM_WORDS)) mem_execute_inst (
        .clk                 (clk),
        .reset               (reset),
        .uop                 (mem_uop),
        .mem_rd_index        (mem_rd_index),
        .pending_store_valid (pending_store_valid),
        .pending_store_index (pending_store_index),
        .wb_valid            (wb_valid),
        .wb_rd               (wb_rd),
        .wb_value            (wb_value),
        .retire_valid        (retire_valid),
        .retire              (retire)
    );

endmodule

// ==== verification/pipe_core_tb.sv ====
module pipe_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import core_pkg::*;

    localparam int MEM_WORDS = 16;
    localparam int N_RANDOM = 400;
    localparam int N_DIRECTED = 60;
    localparam int WATCHDOG_CYCLES = (N_RANDOM + N_DIRECTED) * 4 + 100;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic [15:0] instr;
    logic        stall;
    logic        retire_valid;
    retire_t     retire;

    logic [DATA_W-1:0] model_regs [4];
    logic [DATA_W-1:0] model_mem [MEM_WORDS];
    retire_t           expected_q [$];

    int          seed;
    int          errors;
    int          issued;
    int          retired;
    int          stall_total;
    int          stall_before;
    int          stall_expected;
    logic        last_was_store;
    int          last_store_idx;
    logic [31:0] rnd;

    pipe_core #(.MEM_WORDS(MEM_WORDS)) pipe_core_inst (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .stall        (stall),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAILED %s: got %h, expected %h at %0t", name, got, expected, $time);
            errors++;
        end
    endtask

    function automatic int mem_index(input logic [DATA_W-1:0] addr);
        return int'(addr % DATA_W'(MEM_WORDS));
    endfunction

    function automatic logic [15:0] encode(input op_e op, input int rd, input int rs,
                                           input int imm);
        return {op, 2'(rd), 2'(rs), 9'(imm)};
    endfunction

    // applies one instruction to the model state in program order.
    // returns 0 for a nop, which retires nothing.
    function automatic logic apply_instr(input logic [15:0] word, output retire_t rec);
        op_e               op;
        logic [1:0]        rd;
        logic [1:0]        rs;
        logic [DATA_W-1:0] imm;
        logic [DATA_W-1:0] addr;
        op   = op_e'(word[15:13]);
        rd   = word[12:11];
        rs   = word[10:9];
        imm  = DATA_W'($signed(word[8:0]));
        addr = model_regs[rs] + imm;
        rec  = '0;
        rec.rd = rd;
        case (op)
            op_nop:  return 1'b0;
            op_add:  model_regs[rd] = model_regs[rd] + model_regs[rs];
            op_sub:  model_regs[rd] = model_regs[rd] - model_regs[rs];
            op_and:  model_regs[rd] = model_regs[rd] & model_regs[rs];
            op_xor:  model_regs[rd] = model_regs[rd] ^ model_regs[rs];
            op_addi: model_regs[rd] = model_regs[rd] + imm;
            op_load: begin
                model_regs[rd] = model_mem[mem_index(addr)];
                rec.addr = addr;
            end
            op_store: begin
                model_mem[mem_index(addr)] = model_regs[rd];
                rec.is_store = 1'b1;
                rec.addr = addr;
            end
        endcase
        rec.value = model_regs[rd];
        return 1'b1;
    endfunction

    // presents one word and returns on the edge that accepts it.
    // the stall cycles seen while waiting belong to the instruction before.
    task automatic send(input logic valid, input logic [15:0] word);
        retire_t rec;
        logic    has_rec;
        int      waited;
        has_rec = 1'b0;
        rec = '0;
        if (valid) begin
            has_rec = apply_instr(word, rec);
        end
        if (has_rec) begin
            expected_q.push_back(rec);
        end
        instr_valid <= valid;
        instr <= word;
        waited = 0;
        @(posedge clk);
        while (stall) begin
            waited++;
            @(posedge clk);
        end
        compare("stall_cycles", waited, stall_expected);
        stall_total += waited;
        // a load right behind a store to the same word must wait one cycle.
        stall_expected = (has_rec && word[15:13] == op_load && last_was_store &&
                          mem_index(rec.addr) == last_store_idx) ? 1 : 0;
        last_was_store = has_rec && rec.is_store;
        last_store_idx = mem_index(rec.addr);
        if (valid) begin
            issued++;
        end
    endtask

    always @(posedge clk) begin
        retire_t exp_rec;
        if (!reset && retire_valid) begin
            if (expected_q.size() == 0) begin
                $display("a retire appeared with no instruction outstanding at %0t", $time);
                errors++;
            end else begin
                exp_rec = expected_q.pop_front();
                compare("retire.rd", 32'(retire.rd), 32'(exp_rec.rd));
                compare("retire.value", retire.value, exp_rec.value);
                compare("retire.is_store", 32'(retire.is_store), 32'(exp_rec.is_store));
                compare("retire.addr", retire.addr, exp_rec.addr);
                retired++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, the pipeline stopped making progress",
                 WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        seed = 32'h83fd;
        errors = 0;
        issued = 0;
        retired = 0;
        stall_total = 0;
        stall_expected = 0;
        last_was_store = 1'b0;
        last_store_idx = 0;
        for (int i = 0; i < 4; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        reset = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // quiet cycles after reset.
        repeat (4) begin
            send(1'b0, 16'h0000);
            compare("stall", 32'(stall), 32'h0);
            compare("retire_valid", 32'(retire_valid), 32'h0);
        end

        // alu program with back-to-back dependencies.
        send(1'b1, encode(op_addi, 0, 0, 5));
        send(1'b1, encode(op_addi, 1, 0, -3));
        send(1'b1, encode(op_add, 0, 1, 0));
        send(1'b1, encode(op_sub, 1, 0, 0));
        send(1'b1, encode(op_addi, 2, 3, 255));
        send(1'b1, encode(op_and, 2, 1, 0));
        send(1'b1, encode(op_xor, 2, 0, 0));
        send(1'b1, encode(op_xor, 1, 1, 0));
        send(1'b1, encode(op_addi, 3, 0, -256));
        send(1'b1, encode(op_add, 3, 3, 0));
        send(1'b1, encode(op_sub, 0, 3, 0));
        send(1'b1, encode(op_and, 0, 0, 0));

        // stores and loads with wrap-around and negative offsets.
        send(1'b1, encode(op_addi, 1, 0, 77));
        send(1'b1, encode(op_store, 1, 2, 3));
        send(1'b1, encode(op_nop, 0, 0, 0));
        send(1'b1, encode(op_load, 0, 2, 3));
        send(1'b1, encode(op_load, 3, 2, 19));
        send(1'b1, encode(op_load, 3, 2, -13));
        // never written, reads zero.
        send(1'b1, encode(op_load, 0, 2, 9));
        send(1'b1, encode(op_store, 3, 1, -100));
        send(1'b1, encode(op_addi, 2, 0, 1));
        send(1'b1, encode(op_load, 2, 1, -100));
        send(1'b1, encode(op_load, 1, 2, -256));

        // loads right behind stores.
        stall_before = stall_total;
        send(1'b1, encode(op_addi, 0, 0, 11));
        send(1'b1, encode(op_store, 0, 1, 4));
        send(1'b1, encode(op_load, 3, 1, 4));
        send(1'b1, encode(op_add, 3, 0, 0));
        send(1'b1, encode(op_store, 3, 1, 5));
        send(1'b1, encode(op_load, 2, 1, 6));
        send(1'b1, encode(op_store, 2, 1, 21));
        send(1'b1, encode(op_load, 0, 1, 5));
        send(1'b1, encode(op_load, 1, 0, 0));
        if (stall_total == stall_before) begin
            $display("no stall was seen for a load right behind a store to its word");
            errors++;
        end

        // nops and idle cycles between real instructions.
        send(1'b1, encode(op_addi, 0, 0, 1));
        send(1'b1, encode(op_nop, 3, 2, 100));
        send(1'b0, encode(op_addi, 1, 1, 50));
        send(1'b1, encode(op_addi, 1, 0, 2));
        send(1'b0, encode(op_store, 0, 0, 0));
        send(1'b0, encode(op_load, 0, 0, 0));
        send(1'b1, encode(op_store, 1, 0, 7));
        send(1'b1, encode(op_nop, 0, 0, 0));
        send(1'b1, encode(op_load, 2, 0, 7));
        send(1'b1, encode(op_xor, 2, 1, 0));

        for (int i = 0; i < N_RANDOM; i++) begin
            rnd = $random(seed);
            send(1'b1, rnd[15:0]);
        end

        // drain the pipeline.
        repeat (6) send(1'b0, 16'h0000);
        if (expected_q.size() != 0) begin
            $display("%0d expected retires never appeared", expected_q.size());
            errors++;
        end

        $display("%0d issued, %0d retired, %0d stall cycles, %0d errors",
                 issued, retired, stall_total, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/core_pkg.sv
hw/pipe_latch.sv
hw/uop_decode.sv
hw/rrag_stage.sv
hw/mem_execute.sv
hw/pipe_core.sv
verification/pipe_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the pipe_core testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module pipe_core_tb --Mdir obj_dir \
    -o pipe_core_sim -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/pipe_core_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q '^\*\* PASS \*\*$'; then
    exit 0
fi
exit 1
